// File: list.f
+incdir+common
common/tlk2711_reg_pkg.sv
common/tlk2711_link_pkg.sv
hw/reg_mgt.sv
tlk2711_tx/tlk2711_tx_data.sv
tlk2711_rx/tlk2711_rx_link.sv
hw/tlk2711_top.sv
test/tb_clk_gen.sv
test/tb_tlk2711.sv

// File: run.sh
#!/bin/sh
# build the tlk2711 testbench with verilator, run it, judge from the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f \
    --top-module tb_tlk2711 -o tb_tlk2711_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_tlk2711_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" sim.log; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi

// File: test/tb_tlk2711.sv
// tlk2711 link controller testbench
// transmit lane looped back into the receiver with one cycle of delay,
// error injection, link loss and soft reset against a reference model
`timescale 1ns/1ps
`include "tlk2711_defines.svh"

module tb_tlk2711;
    import tlk2711_reg_pkg::*;
    import tlk2711_link_pkg::*;

    // longest frame plus gap, and the number of frames and transfers run
    localparam int MAX_FRAME   = 16 + 4 + `TLK_IDLE_GAP;
    localparam int N_FRAMES    = 17;
    localparam int N_XFER      = 15;
    localparam int CYCLE_LIMIT = 2 * N_FRAMES * MAX_FRAME + N_XFER * 40
                                 + 2 * `TLK_LOSS_WINDOW + 200;
    localparam tlk_lane_t IDLE_LANE = '{word: `TLK_K_IDLE, kmsb: 1'b1, klsb: 1'b0};

    logic        clk;
    logic        i_rst_n;
    logic        i_reg_wen;
    reg_addr_t   i_reg_waddr;
    reg_data_t   i_reg_wdata;
    logic        i_reg_ren;
    reg_addr_t   i_reg_raddr;
    reg_data_t   o_reg_rdata;
    logic        o_tx_irq;
    logic        o_rx_irq;
    logic        o_loss_irq;
    tlk_lane_t   i_rx_lane;
    tlk_lane_t   o_tx_lane;
    logic        o_tlk_enable;
    logic        o_tlk_loopen;

    tlk_lane_t   rx_pipe;
    logic        force_zero;
    logic        flip_arm;
    logic        csum_fix;
    tlk_word_t   csum_adj;
    int          flip_pos;
    int          word_pos;
    int          cur_body;
    int          mon_frame;
    logic [15:0] lfsr;
    logic [4:0]  ctrl_lvl;
    rx_stat_t    model;
    int          hi_cnt [3];
    int          seen [3];
    int          cycles;

    tb_clk_gen #(.PERIOD_NS(20.0)) tb_clk_gen_i (.o_clk(clk));

    tlk2711_top tlk2711_top_i (.*);

    //////////////////////////////////////////////////
    // reporting
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] t=%0d ns %s got 0x%0h expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // reference model from the frame format
    function automatic tlk_word_t ref_csum(input int hdr, input int len);
        tlk_word_t sum;
        sum = 16'(hdr);
        for (int i = 0; i < len; i++) begin
            sum = sum + 16'(hdr + i);
        end
        return sum;
    endfunction

    function automatic rx_stat_t ref_status(input rx_stat_t prev, input int hdr,
                                            input int len, input logic bad);
        rx_stat_t nxt;
        nxt           = prev;
        nxt.frame_cnt = prev.frame_cnt + 32'd1;
        nxt.err_cnt   = prev.err_cnt + (bad ? 32'd1 : 32'd0);
        nxt.last_len  = 16'(len);
        nxt.last_hdr  = 16'(hdr);
        return nxt;
    endfunction

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic string irq_name(input int k);
        case (k)
            0:       return "o_tx_irq";
            1:       return "o_rx_irq";
            default: return "o_loss_irq";
        endcase
    endfunction

    //////////////////////////////////////////////////
    // watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            stop_run("timeout: the DUT did not finish the tests within the cycle limit");
        end
    end

    // loopback into the receiver, plus frame format check on the tx lane
    always @(posedge clk) begin
        tlk_lane_t tx_now;
        tlk_word_t exp_word;
        #1;
        tx_now    = o_tx_lane;
        i_rx_lane = force_zero ? tlk_lane_t'('0) : rx_pipe;
        rx_pipe   = tx_now;
        if (tx_now.kmsb && tx_now.klsb && tx_now.word == `TLK_K_SOF) begin
            word_pos = 0;
        end else if (tx_now.kmsb && tx_now.klsb && tx_now.word == `TLK_K_EOF) begin
            check_value("tx frame words", word_pos, cur_body + 2);
            mon_frame++;
        end else if (!tx_now.kmsb && !tx_now.klsb) begin
            // header, then header + i, then checksum
            if (word_pos == 0) begin
                exp_word = 16'(mon_frame);
            end else if (word_pos <= cur_body) begin
                exp_word = 16'(mon_frame + word_pos - 1);
            end else begin
                exp_word = ref_csum(mon_frame, cur_body);
            end
            check_value("o_tx_lane.word", tx_now.word, exp_word);
            if (flip_arm && word_pos == flip_pos) begin
                rx_pipe.word = rx_pipe.word ^ 16'h0100;
                csum_adj     = rx_pipe.word - tx_now.word;
                flip_arm     = 1'b0;
            end else if (csum_fix && !flip_arm && word_pos == cur_body + 1) begin
                // checksum follows the altered payload
                rx_pipe.word = rx_pipe.word + csum_adj;
                csum_fix     = 1'b0;
            end
            word_pos++;
        end
    end

    // irq width, counted over each high stretch
    always @(posedge clk) begin
        logic [2:0] lvl;
        #1;
        lvl = {o_loss_irq, o_rx_irq, o_tx_irq};
        for (int k = 0; k < 3; k++) begin
            if (lvl[k]) begin
                hi_cnt[k]++;
            end else if (hi_cnt[k] != 0) begin
                check_value(irq_name(k), hi_cnt[k], `TLK_IRQ_WIDTH);
                hi_cnt[k] = 0;
                seen[k]++;
            end
        end
    end

    //////////////////////////////////////////////////
    // register port and stimulus tasks
    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        #1;
        i_reg_wen   = 1'b1;
        i_reg_waddr = addr;
        i_reg_wdata = data;
        @(posedge clk);
        #1;
        i_reg_wen = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        #1;
        i_reg_ren   = 1'b1;
        i_reg_raddr = addr;
        @(posedge clk);
        #1;
        i_reg_ren = 1'b0;
        data      = o_reg_rdata;
    endtask

    task automatic arm_word_flip(input int pos, input logic fix_csum);
        flip_pos = pos;
        flip_arm = 1'b1;
        csum_fix = fix_csum;
    endtask

    task automatic force_silence(input int n);
        @(negedge clk);
        force_zero = 1'b1;
        repeat (n) @(negedge clk);
        force_zero = 1'b0;
    endtask

    task automatic check_rx_status();
        reg_data_t rd;
        reg_read(`TLK_REG_RX_CNT, rd);
        check_value("rx_cnt.frame_cnt", rd[31:0], model.frame_cnt);
        check_value("rx_cnt.err_cnt", rd[63:32], model.err_cnt);
        reg_read(`TLK_REG_RX_LAST, rd);
        check_value("rx_last.last_len", rd[15:0], model.last_len);
        check_value("rx_last.last_hdr", rd[31:16], model.last_hdr);
        reg_read(`TLK_REG_STATUS, rd);
        check_value("status", rd, {62'b0, model.link_loss, 1'b0});
    endtask

    task automatic run_transfer(input int body, input int frames, input logic bad);
        int        tx_before;
        int        rx_before;
        reg_data_t rd;
        reg_write(`TLK_REG_TX_CFG, {32'b0, 16'(frames), 16'(body)});
        cur_body  = body;
        tx_before = seen[0];
        rx_before = seen[1];
        reg_write(`TLK_REG_CTRL, {59'b0, ctrl_lvl | 5'b00001});
        // header is the frame count since soft reset
        for (int f = 0; f < frames; f++) begin
            model = ref_status(model, int'(model.frame_cnt), body, bad && f == 0);
        end
        // both irqs must run out before the counters are read
        while (seen[0] == tx_before || seen[1] < rx_before + frames) begin
            @(negedge clk);
        end
        check_rx_status();
        reg_read(`TLK_REG_TX_CFG, rd);
        check_value("tx_cfg", rd, {32'b0, 16'(frames), 16'(body)});
    endtask

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        int        loss_before;
        reg_data_t rd;
        i_rst_n     = 1'b0;
        i_reg_wen   = 1'b0;
        i_reg_waddr = '0;
        i_reg_wdata = '0;
        i_reg_ren   = 1'b0;
        i_reg_raddr = '0;
        rx_pipe     = IDLE_LANE;
        i_rx_lane   = IDLE_LANE;
        force_zero  = 1'b0;
        flip_arm    = 1'b0;
        csum_fix    = 1'b0;
        csum_adj    = '0;
        flip_pos    = 0;
        word_pos    = 0;
        cur_body    = 0;
        mon_frame   = 0;
        lfsr        = 16'd41;
        ctrl_lvl    = '0;
        model       = '0;
        cycles      = 0;
        repeat (8) @(posedge clk);
        #1;
        i_rst_n = 1'b1;

        // state after reset
        check_value("o_tx_irq", o_tx_irq, 0);
        check_value("o_rx_irq", o_rx_irq, 0);
        check_value("o_loss_irq", o_loss_irq, 0);
        check_value("o_tx_lane", o_tx_lane, IDLE_LANE);
        check_value("o_tlk_enable", o_tlk_enable, 1);
        check_value("o_tlk_loopen", o_tlk_loopen, 0);
        check_rx_status();
        reg_read(16'h0028, rd);
        check_value("unmapped readback", rd, 0);

        run_transfer(5, 1, 1'b0);

        // random body lengths, then one multi-frame transfer
        ctrl_lvl = 5'b00100;
        for (int n = 0; n < 8; n++) begin
            run_transfer(1 + rand_bits(4), 1, 1'b0);
        end
        run_transfer(1 + rand_bits(4), 3, 1'b0);
        check_value("o_tlk_loopen", o_tlk_loopen, 1);

        // pattern check on, clean frame then one flipped payload word
        // with a matching checksum
        ctrl_lvl = 5'b01000;
        run_transfer(4, 1, 1'b0);
        arm_word_flip(2, 1'b1);
        run_transfer(6, 1, 1'b1);
        // pattern check off, same corruption is not counted
        ctrl_lvl = 5'b00000;
        arm_word_flip(2, 1'b1);
        run_transfer(6, 1, 1'b0);
        // flipped checksum word
        arm_word_flip(7, 1'b0);
        run_transfer(6, 1, 1'b1);

        // k-silence on the receive lane
        ctrl_lvl = 5'b10000;
        reg_write(`TLK_REG_CTRL, {59'b0, ctrl_lvl});
        loss_before = seen[2];
        force_silence(`TLK_LOSS_WINDOW + 8);
        while (seen[2] == loss_before) begin
            @(negedge clk);
        end
        model.link_loss = 1'b1;
        check_rx_status();

        // soft reset clears the flag, counters and frame index
        reg_write(`TLK_REG_CTRL, {59'b0, ctrl_lvl | 5'b00010});
        model     = '0;
        mon_frame = 0;
        check_rx_status();
        run_transfer(3, 1, 1'b0);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: test/tb_clk_gen.sv
// testbench clock source
// free-running clock, low at time zero
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule

// File: hw/tlk2711_top.sv
// tlk2711 serial link controller top
// register block, transmit framer and receive link block
`timescale 1ns/1ps
`include "tlk2711_defines.svh"

module tlk2711_top (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_reg_wen,
    input  tlk2711_reg_pkg::reg_addr_t  i_reg_waddr,
    input  tlk2711_reg_pkg::reg_data_t  i_reg_wdata,
    input  logic                        i_reg_ren,
    input  tlk2711_reg_pkg::reg_addr_t  i_reg_raddr,
    output tlk2711_reg_pkg::reg_data_t  o_reg_rdata,
    output logic                        o_tx_irq,
    output logic                        o_rx_irq,
    output logic                        o_loss_irq,
    input  tlk2711_link_pkg::tlk_lane_t i_rx_lane,
    output tlk2711_link_pkg::tlk_lane_t o_tx_lane,
    output logic                        o_tlk_enable,
    output logic                        o_tlk_loopen
);
    import tlk2711_reg_pkg::*;

    tx_cfg_t  tx_cfg;
    rx_cfg_t  rx_cfg;
    rx_stat_t rx_stat;
    logic     tx_start;
    logic     soft_rst;
    logic     tx_busy;
    logic     tx_done;
    logic     rx_frame;
    logic     loss;

    reg_mgt reg_mgt_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_reg_wen    (i_reg_wen),
        .i_reg_waddr  (i_reg_waddr),
        .i_reg_wdata  (i_reg_wdata),
        .i_reg_ren    (i_reg_ren),
        .i_reg_raddr  (i_reg_raddr),
        .o_reg_rdata  (o_reg_rdata),
        .i_tx_busy    (tx_busy),
        .i_tx_done    (tx_done),
        .i_rx_stat    (rx_stat),
        .i_rx_frame   (rx_frame),
        .i_loss       (loss),
        .o_tx_cfg     (tx_cfg),
        .o_rx_cfg     (rx_cfg),
        .o_tx_start   (tx_start),
        .o_soft_rst   (soft_rst),
        .o_tlk_loopen (o_tlk_loopen),
        .o_tx_irq     (o_tx_irq),
        .o_rx_irq     (o_rx_irq),
        .o_loss_irq   (o_loss_irq)
    );

    tlk2711_tx_data tlk2711_tx_data_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_soft_rst   (soft_rst),
        .i_tx_start   (tx_start),
        .i_tx_cfg     (tx_cfg),
        .o_tx_lane    (o_tx_lane),
        .o_tlk_enable (o_tlk_enable),
        .o_tx_busy    (tx_busy),
        .o_tx_done    (tx_done)
    );

    tlk2711_rx_link tlk2711_rx_link_i (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_soft_rst (soft_rst),
        .i_rx_cfg   (rx_cfg),
        .i_rx_lane  (i_rx_lane),
        .o_rx_stat  (rx_stat),
        .o_rx_frame (rx_frame),
        .o_loss     (loss)
    );

endmodule

// File: tlk2711_rx/tlk2711_rx_link.sv
// tlk2711 receive link block
// frame parser with checksum and pattern check, frame and error
// counters, and a k-silence link-loss detector
`timescale 1ns/1ps
`include "tlk2711_defines.svh"

module tlk2711_rx_link (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_soft_rst,
    input  tlk2711_reg_pkg::rx_cfg_t    i_rx_cfg,
    input  tlk2711_link_pkg::tlk_lane_t i_rx_lane,
    output tlk2711_reg_pkg::rx_stat_t   o_rx_stat,
    output logic                        o_rx_frame,
    output logic                        o_loss
);
    import tlk2711_reg_pkg::*;
    import tlk2711_link_pkg::*;

    localparam int LOSS_W = $clog2(`TLK_LOSS_WINDOW + 1);

    rx_state_e         state;
    logic              held_vld;
    tlk_word_t         held;
    tlk_word_t         sum;
    tlk_word_t         exp_word;
    frame_cnt_t        hdr;
    body_len_t         len;
    logic              pat_err;
    logic [31:0]       frame_cnt;
    logic [31:0]       err_cnt;
    body_len_t         last_len;
    frame_cnt_t        last_hdr;
    logic              link_loss;
    logic [LOSS_W-1:0] silence_cnt;
    logic              k_any;
    logic              is_sof;
    logic              is_eof;
    logic              csum_bad;

    assign k_any  = i_rx_lane.kmsb | i_rx_lane.klsb;
    assign is_sof = i_rx_lane.kmsb & i_rx_lane.klsb & (i_rx_lane.word == `TLK_K_SOF);
    assign is_eof = i_rx_lane.kmsb & i_rx_lane.klsb & (i_rx_lane.word == `TLK_K_EOF);
    // last held word is the checksum
    assign csum_bad = !held_vld || (held != sum);

    //////////////////////////////////////////////////
    // parser and counters
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_soft_rst) begin
            state      <= RX_HUNT;
            held_vld   <= 1'b0;
            o_rx_frame <= 1'b0;
            frame_cnt  <= '0;
            err_cnt    <= '0;
            last_len   <= '0;
            last_hdr   <= '0;
        end else begin
            o_rx_frame <= 1'b0;
            if (is_sof) begin
                // sof anywhere restarts the parse
                state <= RX_HDR;
            end else begin
                case (state)
                    RX_HDR: begin
                        if (!k_any) begin
                            state    <= RX_DATA;
                            held_vld <= 1'b0;
                        end
                    end
                    RX_DATA: begin
                        if (is_eof) begin
                            state      <= RX_HUNT;
                            o_rx_frame <= 1'b1;
                            frame_cnt  <= frame_cnt + 1'b1;
                            last_len   <= len;
                            last_hdr   <= hdr;
                            if (csum_bad || pat_err) begin
                                err_cnt <= err_cnt + 1'b1;
                            end
                        end else if (!k_any) begin
                            held_vld <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // one-word holdback, data is only non-k words
    always_ff @(posedge clk) begin
        if (state == RX_HDR && !k_any) begin
            hdr      <= i_rx_lane.word;
            sum      <= i_rx_lane.word;
            exp_word <= i_rx_lane.word;
            len      <= '0;
            pat_err  <= 1'b0;
        end else if (state == RX_DATA && !k_any && held_vld) begin
            sum      <= sum + held;
            exp_word <= exp_word + 1'b1;
            len      <= len + 1'b1;
            if (i_rx_cfg.check_ena && held != exp_word) begin
                pat_err <= 1'b1;
            end
        end
        if (state == RX_DATA && !k_any) begin
            held <= i_rx_lane.word;
        end
    end

    //////////////////////////////////////////////////
    // link loss, sticky until soft reset
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_soft_rst) begin
            silence_cnt <= '0;
            link_loss   <= 1'b0;
            o_loss      <= 1'b0;
        end else begin
            o_loss <= 1'b0;
            if (k_any) begin
                silence_cnt <= '0;
            end else if (silence_cnt != LOSS_W'(`TLK_LOSS_WINDOW)) begin
                silence_cnt <= silence_cnt + 1'b1;
            end
            if (i_rx_cfg.loss_det_ena && !k_any && !link_loss &&
                silence_cnt >= LOSS_W'(`TLK_LOSS_WINDOW - 1)) begin
                link_loss <= 1'b1;
                o_loss    <= 1'b1;
            end
        end
    end

    assign o_rx_stat.frame_cnt = frame_cnt;
    assign o_rx_stat.err_cnt   = err_cnt;
    assign o_rx_stat.last_len  = last_len;
    assign o_rx_stat.last_hdr  = last_hdr;
    assign o_rx_stat.link_loss = link_loss;

endmodule

// File: tlk2711_tx/tlk2711_tx_data.sv
// tlk2711 transmit framer
// sends counting-pattern test frames delimited by k characters,
// idles between frames and whenever not busy
`timescale 1ns/1ps
`include "tlk2711_defines.svh"

module tlk2711_tx_data (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_soft_rst,
    input  logic                        i_tx_start,
    input  tlk2711_reg_pkg::tx_cfg_t    i_tx_cfg,
    output tlk2711_link_pkg::tlk_lane_t o_tx_lane,
    output logic                        o_tlk_enable,
    output logic                        o_tx_busy,
    output logic                        o_tx_done
);
    import tlk2711_reg_pkg::*;
    import tlk2711_link_pkg::*;

    localparam int GAP_W = $clog2(`TLK_IDLE_GAP + 1);

    tx_state_e        state;
    // header index runs on across transfers until soft reset
    frame_cnt_t       frame_idx;
    frame_cnt_t       sent_cnt;
    body_len_t        word_cnt;
    logic [GAP_W-1:0] gap_cnt;
    tlk_word_t        pat;
    tlk_word_t        csum;

    //////////////////////////////////////////////////
    // frame sequencer
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_soft_rst) begin
            state     <= TX_IDLE;
            frame_idx <= '0;
            sent_cnt  <= '0;
            word_cnt  <= '0;
            gap_cnt   <= '0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    // start while busy never reaches here
                    if (i_tx_start && i_tx_cfg.frame_num != '0) begin
                        state    <= TX_SOF;
                        sent_cnt <= '0;
                    end
                end
                TX_SOF: state <= TX_HDR;
                TX_HDR: begin
                    word_cnt <= '0;
                    state    <= (i_tx_cfg.body_num == '0) ? TX_CSUM : TX_BODY;
                end
                TX_BODY: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == i_tx_cfg.body_num - 1'b1) begin
                        state <= TX_CSUM;
                    end
                end
                TX_CSUM: state <= TX_EOF;
                TX_EOF: begin
                    frame_idx <= frame_idx + 1'b1;
                    sent_cnt  <= sent_cnt + 1'b1;
                    if (sent_cnt == i_tx_cfg.frame_num - 1'b1) begin
                        state     <= TX_IDLE;
                        o_tx_done <= 1'b1;
                    end else begin
                        state   <= TX_GAP;
                        gap_cnt <= '0;
                    end
                end
                TX_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_W'(`TLK_IDLE_GAP - 1)) begin
                        state <= TX_SOF;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // payload pattern and running checksum
    always_ff @(posedge clk) begin
        if (state == TX_HDR) begin
            pat  <= frame_idx;
            csum <= frame_idx;
        end else if (state == TX_BODY) begin
            pat  <= pat + 1'b1;
            csum <= csum + pat;
        end
    end

    //////////////////////////////////////////////////
    // lane word for the current state
    always_comb begin
        o_tx_lane.word = `TLK_K_IDLE;
        o_tx_lane.kmsb = 1'b1;
        o_tx_lane.klsb = 1'b0;
        case (state)
            TX_SOF: begin
                o_tx_lane.word = `TLK_K_SOF;
                o_tx_lane.klsb = 1'b1;
            end
            TX_EOF: begin
                o_tx_lane.word = `TLK_K_EOF;
                o_tx_lane.klsb = 1'b1;
            end
            TX_HDR: begin
                o_tx_lane.word = frame_idx;
                o_tx_lane.kmsb = 1'b0;
            end
            TX_BODY: begin
                o_tx_lane.word = pat;
                o_tx_lane.kmsb = 1'b0;
            end
            TX_CSUM: begin
                o_tx_lane.word = csum;
                o_tx_lane.kmsb = 1'b0;
            end
            default: ;
        endcase
    end

    assign o_tx_busy    = (state != TX_IDLE);
    // transceiver stays enabled
    assign o_tlk_enable = 1'b1;

endmodule

// File: hw/reg_mgt.sv
// tlk2711 register block
// host write decode, control pulses, status readback
// and fixed-width interrupt stretching
`timescale 1ns/1ps
`include "tlk2711_defines.svh"

module reg_mgt (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_reg_wen,
    input  tlk2711_reg_pkg::reg_addr_t  i_reg_waddr,
    input  tlk2711_reg_pkg::reg_data_t  i_reg_wdata,
    input  logic                        i_reg_ren,
    input  tlk2711_reg_pkg::reg_addr_t  i_reg_raddr,
    output tlk2711_reg_pkg::reg_data_t  o_reg_rdata,
    input  logic                        i_tx_busy,
    input  logic                        i_tx_done,
    input  tlk2711_reg_pkg::rx_stat_t   i_rx_stat,
    input  logic                        i_rx_frame,
    input  logic                        i_loss,
    output tlk2711_reg_pkg::tx_cfg_t    o_tx_cfg,
    output tlk2711_reg_pkg::rx_cfg_t    o_rx_cfg,
    output logic                        o_tx_start,
    output logic                        o_soft_rst,
    output logic                        o_tlk_loopen,
    output logic                        o_tx_irq,
    output logic                        o_rx_irq,
    output logic                        o_loss_irq
);
    import tlk2711_reg_pkg::*;

    localparam int IRQ_W = $clog2(`TLK_IRQ_WIDTH + 1);

    reg_data_t  rd_mux;
    logic [2:0] irq_evt;
    logic [2:0] irq_lvl;

    //////////////////////////////////////////////////
    // write decode
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_tx_cfg   <= '0;
            o_rx_cfg   <= '0;
            o_tx_start <= 1'b0;
            o_soft_rst <= 1'b0;
        end else begin
            // pulses last one cycle
            o_tx_start <= 1'b0;
            o_soft_rst <= 1'b0;
            if (i_reg_wen) begin
                case (i_reg_waddr)
                    `TLK_REG_CTRL: begin
                        o_tx_start            <= i_reg_wdata[0];
                        o_soft_rst            <= i_reg_wdata[1];
                        o_tx_cfg.loopen       <= i_reg_wdata[2];
                        o_rx_cfg.check_ena    <= i_reg_wdata[3];
                        o_rx_cfg.loss_det_ena <= i_reg_wdata[4];
                    end
                    `TLK_REG_TX_CFG: begin
                        o_tx_cfg.body_num  <= i_reg_wdata[15:0];
                        o_tx_cfg.frame_num <= i_reg_wdata[31:16];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign o_tlk_loopen = o_tx_cfg.loopen;

    //////////////////////////////////////////////////
    // status readback
    always_comb begin
        case (i_reg_raddr)
            `TLK_REG_TX_CFG:  rd_mux = {32'b0, o_tx_cfg.frame_num, o_tx_cfg.body_num};
            `TLK_REG_STATUS:  rd_mux = {62'b0, i_rx_stat.link_loss, i_tx_busy};
            `TLK_REG_RX_CNT:  rd_mux = {i_rx_stat.err_cnt, i_rx_stat.frame_cnt};
            `TLK_REG_RX_LAST: rd_mux = {32'b0, i_rx_stat.last_hdr, i_rx_stat.last_len};
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reg_ren) begin
            o_reg_rdata <= rd_mux;
        end
    end

    //////////////////////////////////////////////////
    // interrupt stretchers, a new event restarts the count
    assign irq_evt = {i_loss, i_rx_frame, i_tx_done};

    for (genvar g = 0; g < 3; g++) begin : g_irq
        logic [IRQ_W-1:0] cnt;

        always_ff @(posedge clk) begin
            if (!i_rst_n) begin
                cnt <= '0;
            end else if (irq_evt[g]) begin
                cnt <= IRQ_W'(`TLK_IRQ_WIDTH);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end

        assign irq_lvl[g] = (cnt != '0);
    end

    assign o_tx_irq   = irq_lvl[0];
    assign o_rx_irq   = irq_lvl[1];
    assign o_loss_irq = irq_lvl[2];

endmodule

// File: common/tlk2711_link_pkg.sv
// tlk2711 lane-side types
// 16-bit serdes word with k flags, framer and parser states
package tlk2711_link_pkg;

    typedef logic [15:0] tlk_word_t;

    // one lane beat, same shape for tx and rx
    typedef struct packed {
        tlk_word_t word;
        logic      kmsb;
        logic      klsb;
    } tlk_lane_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_SOF,
        TX_HDR,
        TX_BODY,
        TX_CSUM,
        TX_EOF,
        TX_GAP
    } tx_state_e;

    // receive parser
    typedef enum logic [1:0] {
        RX_HUNT,
        RX_HDR,
        RX_DATA
    } rx_state_e;

endpackage

// File: common/tlk2711_reg_pkg.sv
// tlk2711 register-side types
// host register port widths, configuration and status records
package tlk2711_reg_pkg;

    typedef logic [15:0] reg_addr_t;
    typedef logic [63:0] reg_data_t;

    typedef logic [15:0] body_len_t;
    typedef logic [15:0] frame_cnt_t;

    // transmit test configuration
    typedef struct packed {
        body_len_t  body_num;
        frame_cnt_t frame_num;
        logic       loopen;
    } tx_cfg_t;

    typedef struct packed {
        logic check_ena;
        logic loss_det_ena;
    } rx_cfg_t;

    // receive counters and link state
    typedef struct packed {
        logic [31:0] frame_cnt;
        logic [31:0] err_cnt;
        body_len_t   last_len;
        frame_cnt_t  last_hdr;
        logic        link_loss;
    } rx_stat_t;

endpackage

// File: common/tlk2711_defines.svh
// tlk2711 link controller constants
// register map, k-character codes and timing windows
`ifndef TLK2711_DEFINES_SVH
`define TLK2711_DEFINES_SVH

// register addresses, 64-bit aligned
`define TLK_REG_CTRL     16'h0000
`define TLK_REG_TX_CFG   16'h0008
`define TLK_REG_STATUS   16'h0010
`define TLK_REG_RX_CNT   16'h0018
`define TLK_REG_RX_LAST  16'h0020

// k28.5 idle on msb only, sof/eof with both k flags
`define TLK_K_IDLE       16'hBC50
`define TLK_K_SOF        16'hFBFB
`define TLK_K_EOF        16'hFDFD

`define TLK_IDLE_GAP     4
`define TLK_LOSS_WINDOW  64
`define TLK_IRQ_WIDTH    8

`endif
